// File: flist.f
+incdir+design
design/wh_pkg.sv
design/dma_pkg.sv
design/wh_dma_client.sv
design/wh_link_concentrator.sv
design/wh_test_mem.sv
design/wh_mem_subsys.sv
verification/wh_mem_subsys_props.sv
verification/wh_mem_subsys_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 -f flist.f --top-module wh_mem_subsys_tb -o wh_sim &&
./obj_dir/wh_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation run ok" || { echo "simulation run failed"; exit 1; }

// File: verification/wh_mem_subsys_tb.sv
`include "wh_defs.svh"

module wh_mem_subsys_tb
  import dma_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_lp = 200;

  logic clk = 1'b0;
  logic reset;
  logic req_v [`WH_NUM_CLIENTS];
  dma_req_s req [`WH_NUM_CLIENTS];
  logic req_ready [`WH_NUM_CLIENTS];
  logic resp_v [`WH_NUM_CLIENTS];
  dma_resp_s resp [`WH_NUM_CLIENTS];

  logic [31:0] lfsr;
  logic [31:0] addr [`WH_NUM_CLIENTS];
  dma_block_t data [`WH_NUM_CLIENTS];
  int timeouts = 0;
  int total;

  wh_mem_subsys u_wh_mem_subsys (
    .clk_i      (clk),
    .reset_i    (reset),
    .req_v_i    (req_v),
    .req_i      (req),
    .req_ready_o(req_ready),
    .resp_v_o   (resp_v),
    .resp_o     (resp)
  );

  always #20 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic dma_block_t rand_block();
    dma_block_t b;
    for (int w = 0; w < `WH_BLOCK_WORDS; w++) begin
      b[w] = take_bits(32);
    end
    return b;
  endfunction

  // ready is sampled on the falling edge and the request moves on the next rising one
  task automatic send_req(input int c, input logic wr, input logic [31:0] a,
                          input dma_block_t d);
    int n;
    n = 0;
    @(posedge clk);
    req_v[c] <= 1'b1;
    req[c] <= '{write_not_read: wr, block_addr: a, data: d};
    @(negedge clk);
    while (!req_ready[c] && n < timeout_lp) begin
      @(negedge clk);
      n++;
    end
    @(posedge clk);
    req_v[c] <= 1'b0;
    if (n >= timeout_lp) begin
      timeouts++;
      $display("time %0t: client %0d never accepted its request", $time, c);
    end
  endtask

  task automatic wait_resp(input int c);
    int n;
    n = 0;
    @(negedge clk);
    while (!resp_v[c] && n < timeout_lp) begin
      @(negedge clk);
      n++;
    end
    if (n >= timeout_lp) begin
      timeouts++;
      $display("time %0t: client %0d read never completed", $time, c);
    end
  endtask

  task automatic do_block(input int c, input logic wr, input logic [31:0] a,
                          input dma_block_t d);
    send_req(c, wr, a, d);
    if (!wr) begin
      wait_resp(c);
    end
  endtask

  task automatic write_then_read(input int c, input logic [31:0] a, input dma_block_t d);
    do_block(c, 1'b1, a, d);
    do_block(c, 1'b0, a, '0);
  endtask

  initial begin
    lfsr = 32'h0edb9ac9;
    reset = 1'b1;
    for (int c = 0; c < `WH_NUM_CLIENTS; c++) begin
      req_v[c] = 1'b0;
      req[c] = '0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // round trip
    addr[0] = take_bits(32);
    write_then_read(0, addr[0], rand_block());

    // one block address in every client
    for (int c = 0; c < `WH_NUM_CLIENTS; c++) begin
      data[c] = rand_block();
      do_block(c, 1'b1, 32'h5, data[c]);
    end
    for (int c = 0; c < `WH_NUM_CLIENTS; c++) begin
      do_block(c, 1'b0, 32'h5, '0);
    end

    // overwrite and an alias that differs in every bit above the block field
    addr[1] = take_bits(32);
    do_block(1, 1'b1, addr[1], rand_block());
    write_then_read(1, addr[1], rand_block());
    addr[2] = take_bits(32);
    do_block(2, 1'b1, addr[2], rand_block());
    do_block(2, 1'b0, addr[2] ^ (32'hffff_ffff << `WH_BLOCK_ADDR_WIDTH), '0);

    // all clients contend in the concentrator
    repeat (4) begin
      for (int c = 0; c < `WH_NUM_CLIENTS; c++) begin
        addr[c] = take_bits(32);
        data[c] = rand_block();
      end
      fork
        write_then_read(0, addr[0], data[0]);
        write_then_read(1, addr[1], data[1]);
        write_then_read(2, addr[2], data[2]);
        write_then_read(3, addr[3], data[3]);
      join
    end

    repeat (4) @(posedge clk);
    total = timeouts + u_wh_mem_subsys.u_props.fail_cnt;
    $display("errors: %0d (%0d timeouts, %0d assertion failures)", total, timeouts,
             u_wh_mem_subsys.u_props.fail_cnt);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verification/wh_mem_subsys_props.sv
`include "wh_defs.svh"

module wh_mem_subsys_props
  import dma_pkg::*;
  (
    input logic      clk_i,
    input logic      reset_i,
    input logic      req_v_i     [`WH_NUM_CLIENTS],
    input dma_req_s  req_i       [`WH_NUM_CLIENTS],
    input logic      req_ready_i [`WH_NUM_CLIENTS],
    input logic      resp_v_i    [`WH_NUM_CLIENTS],
    input dma_resp_s resp_i      [`WH_NUM_CLIENTS]
  );

  timeunit 1ns;
  timeprecision 1ps;

  localparam int blocks_lp = 1 << `WH_BLOCK_ADDR_WIDTH;

  int fail_cnt = 0;
  dma_block_t shadow [`WH_NUM_CLIENTS][blocks_lp];  // indexed by truncated address
  logic [`WH_BLOCK_ADDR_WIDTH-1:0] rd_addr [`WH_NUM_CLIENTS];
  logic [`WH_NUM_CLIENTS-1:0] rd_open;  // read accepted, not yet answered

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_open <= '0;
    end else begin
      for (int c = 0; c < `WH_NUM_CLIENTS; c++) begin
        if (resp_v_i[c]) begin
          rd_open[c] <= 1'b0;
        end
        // a new request may land in the same cycle as a response
        if (req_v_i[c] && req_ready_i[c]) begin
          if (req_i[c].write_not_read) begin
            shadow[c][req_i[c].block_addr[`WH_BLOCK_ADDR_WIDTH-1:0]] <= req_i[c].data;
          end else begin
            rd_addr[c] <= req_i[c].block_addr[`WH_BLOCK_ADDR_WIDTH-1:0];
            rd_open[c] <= 1'b1;
          end
        end
      end
    end
  end

  for (genvar c = 0; c < `WH_NUM_CLIENTS; c++) begin : g_client
    fill_data_a: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_v_i[c] |-> resp_i[c].data == shadow[c][rd_addr[c]])
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: client %0d block %0d read %h, expected %h", $time, c,
             $sampled(rd_addr[c]), $sampled(resp_i[c].data),
             $sampled(shadow[c][rd_addr[c]]));
    end

    resp_owner_a: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_v_i[c] |-> rd_open[c])
    else begin
      fail_cnt++;
      $error("client %0d gave a response with no read outstanding", c);
    end

    busy_after_accept_a: assert property (@(posedge clk_i) disable iff (reset_i)
      req_v_i[c] && req_ready_i[c] |=> !req_ready_i[c])
    else begin
      fail_cnt++;
      $error("client %0d stayed ready right after taking a request", c);
    end

    busy_until_resp_a: assert property (@(posedge clk_i) disable iff (reset_i)
      rd_open[c] && !resp_v_i[c] |-> !req_ready_i[c])
    else begin
      fail_cnt++;
      $error("client %0d became ready before its read was answered", c);
    end

    reset_quiet_a: assert property (@(posedge clk_i) reset_i |-> !resp_v_i[c])
    else begin
      fail_cnt++;
      $error("client %0d raised a response during reset", c);
    end

    reset_exit_a: assert property (@(posedge clk_i)
      $fell(reset_i) |-> req_ready_i[c] && !resp_v_i[c])
    else begin
      fail_cnt++;
      $error("client %0d was not idle on the first cycle after reset", c);
    end
  end

endmodule

bind wh_mem_subsys wh_mem_subsys_props u_props (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .req_v_i    (req_v_i),
  .req_i      (req_i),
  .req_ready_i(req_ready_o),
  .resp_v_i   (resp_v_o),
  .resp_i     (resp_o)
);

// File: design/wh_mem_subsys.sv
`include "wh_defs.svh"

module wh_mem_subsys
  import wh_pkg::*, dma_pkg::*;
  (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      req_v_i     [`WH_NUM_CLIENTS],
    input  dma_req_s  req_i       [`WH_NUM_CLIENTS],
    output logic      req_ready_o [`WH_NUM_CLIENTS],
    output logic      resp_v_o    [`WH_NUM_CLIENTS],
    output dma_resp_s resp_o      [`WH_NUM_CLIENTS]
  );

  wh_link_s client_to_conc [`WH_NUM_CLIENTS];
  wh_link_s conc_to_client [`WH_NUM_CLIENTS];
  wh_link_s conc_to_mem;
  wh_link_s mem_to_conc;

  for (genvar i = 0; i < `WH_NUM_CLIENTS; i++) begin : g_client
    wh_dma_client #(
      .client_id_p(i)
    ) u_client (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_v_i    (req_v_i[i]),
      .req_i      (req_i[i]),
      .req_ready_o(req_ready_o[i]),
      .resp_v_o   (resp_v_o[i]),
      .resp_o     (resp_o[i]),
      .link_i     (conc_to_client[i]),
      .link_o     (client_to_conc[i])
    );
  end

  wh_link_concentrator u_conc (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .client_link_i(client_to_conc),
    .client_link_o(conc_to_client),
    .mem_link_i   (mem_to_conc),
    .mem_link_o   (conc_to_mem)
  );

  wh_test_mem u_mem (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .link_i (conc_to_mem),
    .link_o (mem_to_conc)
  );

endmodule

// File: design/wh_test_mem.sv
`include "wh_defs.svh"

module wh_test_mem
  import wh_pkg::*;
  (
    input  logic     clk_i,
    input  logic     reset_i,
    input  wh_link_s link_i,
    output wh_link_s link_o
  );

  localparam int cnt_width_lp = $clog2(`WH_BLOCK_WORDS);
  localparam int len_width_lp = `WH_LEN_WIDTH;
  localparam int mem_addr_width_lp = $clog2(`WH_MEM_WORDS);
  localparam logic [cnt_width_lp-1:0] last_word_lp = cnt_width_lp'(`WH_BLOCK_WORDS - 1);

  typedef enum logic [2:0] {
    st_reset,
    st_ready,
    st_recv_addr,
    st_recv_evict,
    st_send_header,
    st_send_data
  } mem_state_e;

  mem_state_e state_r, state_n;
  logic write_not_read_r;
  logic [`WH_CID_WIDTH-1:0] src_cid_r;
  logic [`WH_BLOCK_ADDR_WIDTH-1:0] addr_r;
  logic [cnt_width_lp-1:0] cnt_r, cnt_n;

  logic mem_we;
  logic [mem_addr_width_lp-1:0] mem_addr;
  logic [`WH_FLIT_WIDTH-1:0] mem [`WH_MEM_WORDS];

  wh_header_flit_s hdr_in;
  wh_header_flit_s hdr_out;

  assign hdr_in = link_i.data;

  assign hdr_out.unused = '0;
  assign hdr_out.write_not_read = 1'b0;
  assign hdr_out.src_cid = '0;
  assign hdr_out.cid = src_cid_r;  // back to the requester
  assign hdr_out.len = len_width_lp'(`WH_BLOCK_WORDS);

  // private region per client
  assign mem_addr = {src_cid_r, addr_r, cnt_r};

  always_ff @(posedge clk_i) begin
    if (mem_we) begin
      mem[mem_addr] <= link_i.data;
    end
  end

  always_comb begin
    state_n = state_r;
    cnt_n = cnt_r;
    mem_we = 1'b0;
    link_o = '0;

    case (state_r)
      st_reset: state_n = st_ready;
      st_ready: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          state_n = st_recv_addr;
        end
      end
      st_recv_addr: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          cnt_n = '0;
          state_n = write_not_read_r ? st_recv_evict : st_send_header;
        end
      end
      st_recv_evict: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          mem_we = 1'b1;
          cnt_n = cnt_r + 1'b1;
          state_n = (cnt_r == last_word_lp) ? st_ready : st_recv_evict;
        end
      end
      st_send_header: begin
        link_o.v = 1'b1;
        link_o.data = hdr_out;
        if (link_i.ready_and_rev) begin
          state_n = st_send_data;
        end
      end
      st_send_data: begin
        link_o.v = 1'b1;
        link_o.data = mem[mem_addr];
        if (link_i.ready_and_rev) begin
          cnt_n = cnt_r + 1'b1;
          state_n = (cnt_r == last_word_lp) ? st_ready : st_send_data;
        end
      end
      default: state_n = st_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_reset;
      cnt_r <= '0;
      write_not_read_r <= 1'b0;
      src_cid_r <= '0;
      addr_r <= '0;
    end else begin
      state_r <= state_n;
      cnt_r <= cnt_n;
      if (state_r == st_ready && link_i.v) begin
        write_not_read_r <= hdr_in.write_not_read;
        src_cid_r <= hdr_in.src_cid;
      end
      if (state_r == st_recv_addr && link_i.v) begin
        addr_r <= link_i.data[`WH_BLOCK_ADDR_WIDTH-1:0];  // upper bits alias
      end
    end
  end

endmodule

// File: design/wh_link_concentrator.sv
`include "wh_defs.svh"

module wh_link_concentrator
  import wh_pkg::*;
  (
    input  logic     clk_i,
    input  logic     reset_i,
    input  wh_link_s client_link_i [`WH_NUM_CLIENTS],
    output wh_link_s client_link_o [`WH_NUM_CLIENTS],
    input  wh_link_s mem_link_i,
    output wh_link_s mem_link_o
  );

  localparam int cid_width_lp = `WH_CID_WIDTH;
  localparam int len_width_lp = `WH_LEN_WIDTH;

  // outbound side
  logic [cid_width_lp-1:0] rr_ptr_r;
  logic [cid_width_lp-1:0] out_sel_r, out_sel;
  logic [cid_width_lp-1:0] arb_id, arb_idx;
  logic [len_width_lp-1:0] out_cnt_r;
  logic out_lock_r;
  logic arb_found;
  logic out_fire;
  wh_header_flit_s out_hdr;

  // return side
  logic [cid_width_lp-1:0] ret_sel_r, ret_sel;
  logic [len_width_lp-1:0] ret_cnt_r;
  logic ret_lock_r;
  logic ret_fire;
  wh_header_flit_s ret_hdr;

  // first valid client after the last one granted
  always_comb begin
    arb_found = 1'b0;
    arb_id = rr_ptr_r;
    arb_idx = rr_ptr_r;
    for (int i = 1; i <= `WH_NUM_CLIENTS; i++) begin
      arb_idx = cid_width_lp'((int'(rr_ptr_r) + i) % `WH_NUM_CLIENTS);
      if (!arb_found && client_link_i[arb_idx].v) begin
        arb_found = 1'b1;
        arb_id = arb_idx;
      end
    end
  end

  assign out_sel = out_lock_r ? out_sel_r : arb_id;
  assign out_hdr = client_link_i[out_sel].data;
  assign ret_hdr = mem_link_i.data;
  assign ret_sel = ret_lock_r ? ret_sel_r : ret_hdr.cid;  // steer on the header

  assign mem_link_o.v = client_link_i[out_sel].v;
  assign mem_link_o.data = client_link_i[out_sel].data;
  assign mem_link_o.ready_and_rev = client_link_i[ret_sel].ready_and_rev;

  always_comb begin
    for (int i = 0; i < `WH_NUM_CLIENTS; i++) begin
      client_link_o[i].v = mem_link_i.v && (ret_sel == cid_width_lp'(i));
      client_link_o[i].data = mem_link_i.data;
      client_link_o[i].ready_and_rev = mem_link_i.ready_and_rev
                                       && (out_sel == cid_width_lp'(i));
    end
  end

  assign out_fire = mem_link_o.v && mem_link_i.ready_and_rev;
  assign ret_fire = mem_link_i.v && mem_link_o.ready_and_rev;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_r <= cid_width_lp'(`WH_NUM_CLIENTS - 1);  // client 0 wins first
      out_lock_r <= 1'b0;
      out_sel_r <= '0;
      out_cnt_r <= '0;
      ret_lock_r <= 1'b0;
      ret_sel_r <= '0;
      ret_cnt_r <= '0;
    end else begin
      if (out_fire) begin
        if (!out_lock_r) begin
          out_lock_r <= 1'b1;
          out_sel_r <= arb_id;
          rr_ptr_r <= arb_id;
          out_cnt_r <= out_hdr.len;
        end else begin
          out_cnt_r <= out_cnt_r - 1'b1;
          out_lock_r <= (out_cnt_r != len_width_lp'(1));
        end
      end
      if (ret_fire) begin
        if (!ret_lock_r) begin
          ret_lock_r <= 1'b1;
          ret_sel_r <= ret_hdr.cid;
          ret_cnt_r <= ret_hdr.len;
        end else begin
          ret_cnt_r <= ret_cnt_r - 1'b1;
          ret_lock_r <= (ret_cnt_r != len_width_lp'(1));
        end
      end
    end
  end

endmodule

// File: design/wh_dma_client.sv
`include "wh_defs.svh"

module wh_dma_client
  import wh_pkg::*, dma_pkg::*;
  #(parameter int client_id_p = 0)
  (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      req_v_i,
    input  dma_req_s  req_i,
    output logic      req_ready_o,
    output logic      resp_v_o,
    output dma_resp_s resp_o,
    input  wh_link_s  link_i,
    output wh_link_s  link_o
  );

  localparam int cnt_width_lp = $clog2(`WH_BLOCK_WORDS);
  localparam int len_width_lp = `WH_LEN_WIDTH;
  localparam int cid_width_lp = `WH_CID_WIDTH;
  localparam logic [cnt_width_lp-1:0] last_word_lp = cnt_width_lp'(`WH_BLOCK_WORDS - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_header,
    st_addr,
    st_evict,
    st_fill_wait,
    st_fill_data
  } client_state_e;

  client_state_e state_r, state_n;
  logic [cnt_width_lp-1:0] cnt_r, cnt_n;
  logic resp_v_r;
  logic fill_we;
  logic fill_done;
  dma_req_s req_r;
  dma_resp_s resp_r;
  wh_header_flit_s hdr;

  assign hdr.unused = '0;
  assign hdr.write_not_read = req_r.write_not_read;
  assign hdr.src_cid = cid_width_lp'(client_id_p);
  assign hdr.cid = '0;  // one memory, no routing needed
  assign hdr.len = req_r.write_not_read
    ? len_width_lp'(`WH_BLOCK_WORDS + 1)
    : len_width_lp'(1);

  assign req_ready_o = (state_r == st_idle);
  assign fill_we = (state_r == st_fill_data) && link_i.v;
  assign fill_done = fill_we && (cnt_r == last_word_lp);

  always_comb begin
    state_n = state_r;
    cnt_n = cnt_r;
    link_o = '0;

    case (state_r)
      st_idle: begin
        if (req_v_i) begin
          state_n = st_header;
        end
      end
      st_header: begin
        link_o.v = 1'b1;
        link_o.data = hdr;
        if (link_i.ready_and_rev) begin
          state_n = st_addr;
        end
      end
      st_addr: begin
        link_o.v = 1'b1;
        link_o.data = req_r.block_addr;
        if (link_i.ready_and_rev) begin
          cnt_n = '0;
          state_n = req_r.write_not_read ? st_evict : st_fill_wait;
        end
      end
      st_evict: begin
        link_o.v = 1'b1;
        link_o.data = req_r.data[cnt_r];
        if (link_i.ready_and_rev) begin
          cnt_n = cnt_r + 1'b1;
          if (cnt_r == last_word_lp) begin
            state_n = st_idle;
          end
        end
      end
      st_fill_wait: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin  // header of the fill worm
          state_n = st_fill_data;
        end
      end
      st_fill_data: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          cnt_n = cnt_r + 1'b1;
          if (cnt_r == last_word_lp) begin
            state_n = st_idle;
          end
        end
      end
      default: begin
        state_n = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle;
      cnt_r <= '0;
      resp_v_r <= 1'b0;
    end else begin
      state_r <= state_n;
      cnt_r <= cnt_n;
      resp_v_r <= fill_done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i && req_ready_o) begin
      req_r <= req_i;
    end
    if (fill_we) begin
      resp_r.data[cnt_r] <= link_i.data;
    end
  end

  assign resp_v_o = resp_v_r;
  assign resp_o = resp_r;

endmodule

// File: design/dma_pkg.sv
`include "wh_defs.svh"

package dma_pkg;

  typedef logic [`WH_BLOCK_WORDS-1:0][`WH_FLIT_WIDTH-1:0] dma_block_t;

  typedef struct packed {
    logic                      write_not_read;
    logic [`WH_FLIT_WIDTH-1:0] block_addr;
    dma_block_t                data;  // don't care on a read
  } dma_req_s;

  typedef struct packed {
    dma_block_t data;
  } dma_resp_s;

endpackage

// File: design/wh_pkg.sv
`include "wh_defs.svh"

package wh_pkg;

  // what is left of a flit after the routing fields
  localparam int header_pad_width_lp = `WH_FLIT_WIDTH - 1 - 2 * `WH_CID_WIDTH
                                       - `WH_LEN_WIDTH;

  // one direction of a link, ready_and flows back the other way
  typedef struct packed {
    logic                      v;
    logic [`WH_FLIT_WIDTH-1:0] data;
    logic                      ready_and_rev;
  } wh_link_s;

  typedef struct packed {
    logic [header_pad_width_lp-1:0] unused;
    logic                           write_not_read;
    logic [`WH_CID_WIDTH-1:0]       src_cid;
    logic [`WH_CID_WIDTH-1:0]       cid;  // destination client
    logic [`WH_LEN_WIDTH-1:0]       len;  // flits after the header
  } wh_header_flit_s;

endpackage

// File: design/wh_defs.svh
`ifndef WH_DEFS_SVH
`define WH_DEFS_SVH

`define WH_NUM_CLIENTS 4
`define WH_FLIT_WIDTH 32
`define WH_BLOCK_WORDS 4
`define WH_CID_WIDTH 2
`define WH_LEN_WIDTH 3

// block address bits kept per client
`define WH_BLOCK_ADDR_WIDTH 4
`define WH_MEM_WORDS 256

`endif
